//--- itc_state_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Island tunnel controller states
// Portal light cycle and tunnel arbiter FSM encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package itc_state_pkg;

	// Portal light cycle, same for both portals
	typedef enum logic [1:0] {
		ps_green    = 2'd0, // Light green, no car on entry sensor
		ps_entering = 2'd1, // Car passing entry sensor
		ps_red      = 2'd2, // Light red, tunnel closed from this side
		ps_exiting  = 2'd3  // Car passing exit sensor
	} portal_state_e;

	// Tunnel arbiter FSM
	typedef enum logic [2:0] {
		ts_dispatch     = 3'd0, // Idle, grants straight from here
		ts_island_use   = 3'd1, // Island holds tunnel, mainland waiting
		ts_main_use     = 3'd2, // Mainland holds tunnel, island waiting
		ts_island_clear = 3'd3, // Island done, draining toward mainland
		ts_main_clear   = 3'd4  // Mainland done, draining toward island
	} tunnel_state_e;

endpackage

//--- itc_link_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Island tunnel controller links
// Signal groups passed between portals, arbiter and counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package itc_link_pkg;

	// Portal to arbiter
	typedef struct packed {
		logic in_use;  // Green or entering
		logic request; // Red with a car on the entry sensor
	} portal_req_t;

	// Arbiter to one portal
	typedef struct packed {
		logic go;    // Turn green this edge
		logic yield; // Let current car through, then red
	} tunnel_grant_t;

	// Portal to counter, one cycle per event
	typedef struct packed {
		logic tunnel_inc;  // Car entered tunnel here
		logic tunnel_dec;  // Car left tunnel here
		logic island_step; // Entry from this side
	} count_cmd_t;

	// island_step direction is fixed by which port it arrives on
	// Island side steps down, mainland side steps up

endpackage

//--- island_light_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Island portal light controller
// Runs the portal cycle and reports cars to the counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module island_light_ctrl
	import itc_state_pkg::*, itc_link_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          car_enter,   // ie sensor
	input  logic          car_exit,    // ix sensor
	input  tunnel_grant_t grant,
	output logic          green_light,
	output logic          red_light,
	output portal_req_t   req,
	output count_cmd_t    cmd
);

	portal_state_e state;
	portal_state_e state_nxt;
	logic          car_in;  // Car admitted this cycle

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Light FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ps_red; // Tunnel closed after reset
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ps_green: begin
				if (grant.yield) begin
					state_nxt = ps_red; // Yield beats a waiting car
				end else if (car_enter) begin
					state_nxt = ps_entering;
				end
			end
			ps_entering: begin
				if (!car_enter) begin
					state_nxt = ps_green; // Car through
				end
			end
			ps_red: begin
				if (car_exit) begin
					state_nxt = ps_exiting; // Exit first, ignores go
				end else if (grant.go) begin
					state_nxt = ps_green;
				end
			end
			default: begin // ps_exiting
				if (!car_exit) begin
					state_nxt = ps_red;
				end
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Mealy outputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign car_in      = (state == ps_green) && !grant.yield && car_enter;
	assign green_light = (state == ps_green) || (state == ps_entering);
	assign red_light   = (state == ps_red) || (state == ps_exiting);

	always_comb begin
		req.in_use      = green_light;
		req.request     = (state == ps_red) && car_enter;
		cmd.tunnel_inc  = car_in;
		cmd.tunnel_dec  = (state == ps_red) && car_exit; // First exit edge only
		cmd.island_step = car_in;                        // Counter steps island down
	end

	// Lights are exclusive
	a_lights_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(green_light && red_light));

endmodule

//--- mainland_light_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mainland portal light controller
// Portal cycle plus island capacity check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mainland_light_ctrl
	import itc_state_pkg::*, itc_link_pkg::*;
#(
	parameter int unsigned CNT_W   = 4,
	parameter int unsigned MAX_NUM = 15
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             car_enter,    // me sensor
	input  logic             car_exit,     // mx sensor
	input  tunnel_grant_t    grant,
	input  logic [CNT_W-1:0] island_count,
	output logic             green_light,
	output logic             red_light,
	output portal_req_t      req,
	output count_cmd_t       cmd
);

	localparam logic [CNT_W-1:0] cnt_max = CNT_W'(MAX_NUM);

	portal_state_e state;
	portal_state_e state_nxt;
	logic          island_room; // Island below capacity
	logic          car_in;

	assign island_room = (island_count < cnt_max);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Light FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ps_red;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ps_green: begin
				if (!island_room) begin
					state_nxt = ps_red; // Island full, close portal
				end else if (grant.yield) begin
					state_nxt = ps_red;
				end else if (car_enter) begin
					state_nxt = ps_entering;
				end
			end
			ps_entering: begin
				if (!car_enter) begin
					state_nxt = ps_green;
				end
			end
			ps_red: begin
				if (car_exit) begin
					state_nxt = ps_exiting;
				end else if (grant.go) begin
					state_nxt = ps_green;
				end
			end
			default: begin // ps_exiting
				if (!car_exit) begin
					state_nxt = ps_red;
				end
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Mealy outputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// No entry counted while island full
	assign car_in      = (state == ps_green) && !grant.yield && car_enter && island_room;
	assign green_light = (state == ps_green) || (state == ps_entering);
	assign red_light   = (state == ps_red) || (state == ps_exiting);

	always_comb begin
		req.in_use      = green_light;
		req.request     = (state == ps_red) && car_enter; // Arbiter checks room
		cmd.tunnel_inc  = car_in;
		cmd.tunnel_dec  = (state == ps_red) && car_exit;
		cmd.island_step = car_in;                         // Counter steps island up
	end

	// Every admitted car lands on the island one edge later
	a_entry_counted: assert property (@(posedge clk) disable iff (!rst_n)
		cmd.island_step |=> island_count == $past(island_count) + 1'b1);

endmodule

//--- tunnel_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tunnel arbiter
// One direction at a time, drains tunnel before turning
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tunnel_arbiter
	import itc_state_pkg::*, itc_link_pkg::*;
#(
	parameter int unsigned CNT_W   = 4,
	parameter int unsigned MAX_NUM = 15
) (
	input  logic             clk,
	input  logic             rst_n,
	input  portal_req_t      island_req,
	input  portal_req_t      main_req,
	input  logic [CNT_W-1:0] island_count,
	input  logic [CNT_W-1:0] tunnel_count,
	output tunnel_grant_t    island_grant,
	output tunnel_grant_t    main_grant
);

	localparam logic [CNT_W-1:0] cnt_max = CNT_W'(MAX_NUM);

	tunnel_state_e state;
	tunnel_state_e state_nxt;
	logic          tunnel_empty;
	logic          island_room;
	logic          main_ask;     // Mainland request that can be served

	assign tunnel_empty = (tunnel_count == '0);
	assign island_room  = (island_count < cnt_max);
	// Island request takes priority
	assign main_ask     = !island_req.request && main_req.request && island_room;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Arbiter FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ts_dispatch;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ts_dispatch: begin
				if (island_req.request) begin
					if (main_req.in_use) begin
						state_nxt = ts_main_use;   // Ask mainland to yield
					end else if (!tunnel_empty) begin
						state_nxt = ts_main_clear; // Mainland cars still inside
					end
				end else if (main_ask) begin
					if (island_req.in_use) begin
						state_nxt = ts_island_use;
					end else if (!tunnel_empty) begin
						state_nxt = ts_island_clear;
					end
				end
				// Empty tunnel and idle other side: grant below, stay here
			end
			ts_island_use: begin
				if (!island_req.in_use) begin
					state_nxt = ts_island_clear;
				end
			end
			ts_main_use: begin
				if (!main_req.in_use) begin
					state_nxt = ts_main_clear;
				end
			end
			ts_island_clear, ts_main_clear: begin
				if (tunnel_empty) begin
					state_nxt = ts_dispatch; // Grant goes out on this edge
				end
			end
			default: begin
				state_nxt = ts_dispatch;
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Grants, decoded from state and requests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		island_grant.go    = tunnel_empty &&
			(((state == ts_dispatch) && island_req.request && !main_req.in_use) ||
			(state == ts_main_clear));
		island_grant.yield = (state == ts_island_use);
		main_grant.go      = tunnel_empty &&
			(((state == ts_dispatch) && main_ask && !island_req.in_use) ||
			((state == ts_island_clear) && island_room));
		main_grant.yield   = (state == ts_main_use);
	end

	a_go_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(island_grant.go && main_grant.go));

	// Direction only opens into an empty tunnel
	a_go_empty: assert property (@(posedge clk) disable iff (!rst_n)
		(island_grant.go || main_grant.go) |-> tunnel_count == '0);

endmodule

//--- car_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Car counter
// Saturating counts of cars on the island and in the tunnel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module car_counter
	import itc_link_pkg::*;
#(
	parameter int unsigned CNT_W   = 4,
	parameter int unsigned MAX_NUM = 15
) (
	input  logic             clk,
	input  logic             rst_n,
	input  count_cmd_t       island_cmd,
	input  count_cmd_t       main_cmd,
	output logic [CNT_W-1:0] island_count,
	output logic [CNT_W-1:0] tunnel_count
);

	localparam logic [CNT_W-1:0] cnt_max = CNT_W'(MAX_NUM);

	logic tunnel_cancel; // In on one side, out on the other
	logic tunnel_dec;
	logic tunnel_inc;

	assign tunnel_cancel = (island_cmd.tunnel_dec && main_cmd.tunnel_inc) ||
		(main_cmd.tunnel_dec && island_cmd.tunnel_inc);
	assign tunnel_dec    = island_cmd.tunnel_dec || main_cmd.tunnel_dec;
	assign tunnel_inc    = island_cmd.tunnel_inc || main_cmd.tunnel_inc;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Island occupancy
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			island_count <= '0;
		end else if (island_cmd.island_step && (island_count != '0)) begin
			island_count <= island_count - 1'b1; // Car left for mainland
		end else if (main_cmd.island_step && (island_count < cnt_max)) begin
			island_count <= island_count + 1'b1; // Car headed for island
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tunnel occupancy
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tunnel_count <= '0;
		end else if (tunnel_cancel) begin
			tunnel_count <= tunnel_count; // Net zero
		end else if (tunnel_dec) begin
			if (tunnel_count != '0) begin
				tunnel_count <= tunnel_count - 1'b1;
			end
		end else if (tunnel_inc) begin
			if (tunnel_count < cnt_max) begin
				tunnel_count <= tunnel_count + 1'b1;
			end
		end
	end

	// Arbiter never lets both sides feed the tunnel at once
	a_single_inc: assert property (@(posedge clk) disable iff (!rst_n)
		!(island_cmd.tunnel_inc && main_cmd.tunnel_inc));

endmodule

//--- island_tunnel_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Island tunnel controller top
// Two portals, tunnel arbiter and car counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module island_tunnel_ctrl
	import itc_link_pkg::*;
#(
	parameter int unsigned CNT_W   = 4,
	parameter int unsigned MAX_NUM = 15
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             ie,           // Island entry sensor
	input  logic             ix,           // Island exit sensor
	input  logic             me,           // Mainland entry sensor
	input  logic             mx,           // Mainland exit sensor
	output logic             igl,
	output logic             irl,
	output logic             mgl,
	output logic             mrl,
	output logic [CNT_W-1:0] island_count  // Island display
);

	portal_req_t      island_req;
	portal_req_t      main_req;
	tunnel_grant_t    island_grant;
	tunnel_grant_t    main_grant;
	count_cmd_t       island_cmd;
	count_cmd_t       main_cmd;
	logic [CNT_W-1:0] tunnel_count;

	island_light_ctrl i_island_light_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.car_enter   (ie),
		.car_exit    (ix),
		.grant       (island_grant),
		.green_light (igl),
		.red_light   (irl),
		.req         (island_req),
		.cmd         (island_cmd)
	);

	mainland_light_ctrl #(.CNT_W(CNT_W), .MAX_NUM(MAX_NUM)) i_mainland_light_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.car_enter    (me),
		.car_exit     (mx),
		.grant        (main_grant),
		.island_count (island_count),
		.green_light  (mgl),
		.red_light    (mrl),
		.req          (main_req),
		.cmd          (main_cmd)
	);

	tunnel_arbiter #(.CNT_W(CNT_W), .MAX_NUM(MAX_NUM)) i_tunnel_arbiter (
		.clk          (clk),
		.rst_n        (rst_n),
		.island_req   (island_req),
		.main_req     (main_req),
		.island_count (island_count),
		.tunnel_count (tunnel_count),
		.island_grant (island_grant),
		.main_grant   (main_grant)
	);

	car_counter #(.CNT_W(CNT_W), .MAX_NUM(MAX_NUM)) i_car_counter (
		.clk          (clk),
		.rst_n        (rst_n),
		.island_cmd   (island_cmd),
		.main_cmd     (main_cmd),
		.island_count (island_count),
		.tunnel_count (tunnel_count)
	);

endmodule

//--- tb_island_tunnel_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Island tunnel controller testbench
// Directed portal tests plus LFSR sensor traffic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_island_tunnel_ctrl;

	localparam int unsigned cnt_w    = 4;
	localparam int unsigned max_num  = 3;
	localparam int          wait_max = 60; // Cycles allowed per wait
	localparam logic [cnt_w-1:0] max_cnt = cnt_w'(max_num);

	logic             clk;
	logic             rst_n;
	logic             ie;
	logic             ix;
	logic             me;
	logic             mx;
	logic             igl;
	logic             irl;
	logic             mgl;
	logic             mrl;
	logic [cnt_w-1:0] island_count;

	int               errors;
	int               timeouts;
	logic [31:0]      lfsr;
	logic [cnt_w-1:0] model_count; // Expected cars on the island

	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period

	island_tunnel_ctrl #(.CNT_W(cnt_w), .MAX_NUM(max_num)) i_island_tunnel_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.ie           (ie),
		.ix           (ix),
		.me           (me),
		.mx           (mx),
		.igl          (igl),
		.irl          (irl),
		.mgl          (mgl),
		.mrl          (mrl),
		.island_count (island_count)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr); // One step per bit
			v    = {v[6:0], lfsr[0]};
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2; // Drive and sample point
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		{ie, ix, me, mx} = '0;
		repeat (16) @(posedge clk);
		#2;
		rst_n       = 1'b1;
		model_count = '0;
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("error: %s = %h, expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic expect_count(input logic [cnt_w-1:0] exp);
		assert (island_count === exp) else begin
			$display("error: island_count = %h, expected %h at %0t", island_count, exp, $time);
			errors++;
		end
	endtask

	// Green light of the island side or the mainland side
	function automatic logic pick_light(input int sel);
		if (sel == 0) begin
			return igl;
		end
		return mgl;
	endfunction

	task automatic wait_for_light(input int sel, input logic level, input string name);
		int n;
		n = 0;
		while ((pick_light(sel) !== level) && (n < wait_max)) begin
			next_cycle();
			n++;
		end
		if (pick_light(sel) !== level) begin
			$display("timeout: %s did not go to %0b within %0d cycles", name, level, wait_max);
			timeouts++;
		end
	endtask

	task automatic wait_for_count(input logic [cnt_w-1:0] target);
		int n;
		n = 0;
		while ((island_count !== target) && (n < wait_max)) begin
			next_cycle();
			n++;
		end
		if (island_count !== target) begin
			$display("timeout: island_count never reached %0d", target);
			timeouts++;
		end
	endtask

	// Mainland car in and portal back to green
	task automatic enter_main_car();
		logic [cnt_w-1:0] want;
		want = model_count + 1'b1;
		me = 1'b1;
		wait_for_count(want);
		me          = 1'b0;
		model_count = want;
		next_cycle(); // Entering back to green
	endtask

	task automatic exit_island_car();
		ix = 1'b1;
		next_cycle(); // Red to exiting as tunnel count drops
		ix = 1'b0;
		next_cycle();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_reset_state();
		expect_bit("irl", irl, 1'b1);
		expect_bit("mrl", mrl, 1'b1);
		expect_bit("igl", igl, 1'b0);
		expect_bit("mgl", mgl, 1'b0);
		expect_count('0);
	endtask

	task automatic admit_first_car();
		me = 1'b1;
		next_cycle();
		expect_bit("mgl", mgl, 1'b1); // Grant on first edge with me high
		next_cycle();                 // Car enters on this edge
		me          = 1'b0;
		model_count = model_count + 1'b1;
		expect_count(model_count);
		next_cycle();
		expect_bit("mgl", mgl, 1'b1);
		exit_island_car();
	endtask

	task automatic fill_island();
		while (model_count < max_cnt) begin
			enter_main_car();
			exit_island_car();
		end
		me = 1'b1; // Next car waits at the portal
		wait_for_light(1, 1'b0, "mgl");
		repeat (20) begin
			next_cycle();
			expect_bit("mgl", mgl, 1'b0);
			expect_bit("mrl", mrl, 1'b1);
			expect_count(max_cnt);
		end
		me = 1'b0;
		next_cycle();
	endtask

	task automatic change_direction();
		logic [cnt_w-1:0] want;
		enter_main_car();
		enter_main_car(); // Two cars now in the tunnel
		expect_bit("mgl", mgl, 1'b1);
		ie = 1'b1;
		wait_for_light(1, 1'b0, "mgl"); // Mainland yields
		repeat (8) begin
			next_cycle();
			expect_bit("igl", igl, 1'b0); // Tunnel not drained yet
		end
		exit_island_car();
		expect_bit("igl", igl, 1'b0);
		exit_island_car();
		wait_for_light(0, 1'b1, "igl");
		expect_bit("mgl", mgl, 1'b0);
		repeat (2) begin
			want = model_count - 1'b1;
			next_cycle(); // Green to entering with ie held
			expect_count(want);
			ie          = 1'b0;
			model_count = want;
			next_cycle();
			ie = 1'b1;
		end
		ie = 1'b0;
		next_cycle();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Random traffic with a model count
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic run_random_traffic(input int cycles);
		logic [3:0] sens;       // {ie, ix, me, mx}
		int         hold [4];   // Cycles left per sensor
		logic [7:0] bits;
		logic       igl_pre;
		logic       mgl_pre;
		logic       i_entering; // Model of island entering state
		logic       m_entering;
		sens       = '0;
		i_entering = 1'b0;
		m_entering = 1'b0;
		for (int s = 0; s < 4; s++) begin
			hold[s] = 0;
		end
		for (int c = 0; c < cycles; c++) begin
			igl_pre = igl;
			mgl_pre = mgl;
			for (int s = 0; s < 4; s++) begin
				if (hold[s] == 0) begin
					take_bits(1, bits);
					sens[s] = bits[0];
					take_bits(3, bits);
					hold[s] = int'(bits[2:0]) + 1; // Hold 1 to 8 cycles
				end
				hold[s]--;
			end
			{ie, ix, me, mx} = sens;
			next_cycle();
			// Entry counted when green before and after the edge with the sensor high
			if (mgl_pre && mgl && sens[1] && !m_entering) begin
				if (model_count < max_cnt) begin
					model_count = model_count + 1'b1;
				end
				m_entering = 1'b1;
			end else if (!mgl || !sens[1]) begin
				m_entering = 1'b0;
			end
			if (igl_pre && igl && sens[3] && !i_entering) begin
				if (model_count != '0) begin
					model_count = model_count - 1'b1;
				end
				i_entering = 1'b1;
			end else if (!igl || !sens[3]) begin
				i_entering = 1'b0;
			end
			assert (!(igl && mgl)) else begin
				$display("both green lights on at %0t", $time);
				errors++;
			end
			assert (island_count <= max_cnt) else begin
				$display("error: island_count = %h, above %h", island_count, max_cnt);
				errors++;
			end
			expect_count(model_count);
		end
		{ie, ix, me, mx} = '0;
	endtask

	initial begin
		errors   = 0;
		timeouts = 0;
		lfsr     = 32'hd7f1_86af;
		apply_reset();
		check_reset_state();
		admit_first_car();
		fill_island();
		apply_reset();
		change_direction();
		apply_reset();
		run_random_traffic(400);
		$display("errors %0d, timeouts %0d", errors, timeouts);
		if ((errors == 0) && (timeouts == 0)) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- all.f
itc_state_pkg.sv
itc_link_pkg.sv
island_light_ctrl.sv
mainland_light_ctrl.sv
tunnel_arbiter.sv
car_counter.sv
island_tunnel_ctrl.sv
tb_island_tunnel_ctrl.sv

//--- run.sh
#!/bin/sh
# Build and run the island tunnel controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_island_tunnel_ctrl -f all.f -o sim_tb

out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Done: no errors'; then
	exit 0
fi
exit 1
